//--- include/conv_cfg.svh
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// Samples per vector in x, h and y
`define CONV_LEN 40

// Memory geometry
`define ADDR_W 12
`define MEM_WORDS 4096

// Index inside one 64-word block
`define IDX_W 6

// Value widths
`define SAMPLE_W 16
`define DATA_W 32

// Left shift applied to every finished sum
`define CONV_SHIFT 3

`endif

//--- design/fixpPkg.sv
`include "conv_cfg.svh"

package fixpPkg;

	// Q15 sample, used for x, h and y
	typedef logic signed [`SAMPLE_W-1:0] word16;

	// Q31 accumulator
	typedef logic signed [`DATA_W-1:0] word32;

	// Raw memory word, samples live in the low half
	typedef logic [`DATA_W-1:0] memWord;

	////////////////////////////////////////
	// Saturation limits
	////////////////////////////////////////

	localparam word32 maxWord32 = 32'sh7FFF_FFFF;
	localparam word32 minWord32 = 32'sh8000_0000;

	// Only operand pair whose doubled product overflows
	localparam word16 minWord16 = 16'sh8000;

endpackage

//--- design/convPkg.sv
`include "conv_cfg.svh"

package convPkg;

	typedef logic [`ADDR_W-1:0] memAddr;

	// Block number, lands on address bits 10 to 6
	typedef logic [4:0] blockBase;

	typedef logic [`IDX_W-1:0] sampleIdx;

	typedef enum logic [2:0]
	{
		idle,
		outerCheck,
		innerCheck,
		readH,
		mac,
		shiftReq,
		shiftWait,
		finish
	} convState;

	// Word address of one sample inside a block
	function automatic memAddr makeAddr(blockBase base, sampleIdx idx);
		return memAddr'({base, idx});
	endfunction

endpackage

//--- design/convMemory.sv
`include "conv_cfg.svh"

module convMemory
(
	input logic clk,
	input logic reset,
	input logic hostWriteEn,
	input convPkg::memAddr hostAddr,
	input fixpPkg::memWord hostWriteData,
	output fixpPkg::memWord hostReadData,
	input logic engActive,
	input convPkg::memAddr engAddr,
	input logic engWriteEn,
	input fixpPkg::memWord engWriteData,
	output fixpPkg::memWord engReadData
);

	fixpPkg::memWord mem [`MEM_WORDS];
	fixpPkg::memWord readData;
	fixpPkg::memWord writeData;
	convPkg::memAddr addr;
	logic writeEn;

	// Engine owns the single port for the whole run
	assign addr = engActive ? engAddr : hostAddr;
	assign writeEn = engActive ? engWriteEn : hostWriteEn;
	assign writeData = engActive ? engWriteData : hostWriteData;

	always_ff @(posedge clk)
	begin
		if (writeEn)
			mem[addr] <= writeData;
	end

	// Registered read, returns old data on a same-word write
	always_ff @(posedge clk)
	begin
		if (reset)
			readData <= '0;
		else
			readData <= mem[addr];
	end

	assign hostReadData = readData;
	assign engReadData = readData;

endmodule

//--- design/fixedMac.sv
module fixedMac
(
	input fixpPkg::word32 acc,
	input fixpPkg::word16 a,
	input fixpPkg::word16 b,
	output fixpPkg::word32 result
);

	fixpPkg::word32 rawProduct;
	fixpPkg::word32 product;
	logic signed [32:0] wideSum;

	////////////////////////////////////////
	// L_mult
	////////////////////////////////////////

	// Full 16x16 product always fits in 31 bits plus sign
	assign rawProduct = a * b;

	// Doubling overflows only for -1 times -1
	always_comb
	begin
		if (a == fixpPkg::minWord16 && b == fixpPkg::minWord16)
			product = fixpPkg::maxWord32;
		else
			product = rawProduct <<< 1;
	end

	////////////////////////////////////////
	// L_add
	////////////////////////////////////////

	// One guard bit to catch the carry out of bit 31
	assign wideSum = {acc[31], acc} + {product[31], product};

	always_comb
	begin
		if (wideSum[32] != wideSum[31])
		begin
			// Overflow, clamp towards the sign of the true sum
			if (wideSum[32])
				result = fixpPkg::minWord32;
			else
				result = fixpPkg::maxWord32;
		end
		else
		begin
			result = wideSum[31:0];
		end
	end

endmodule

//--- design/normShifter.sv
`include "conv_cfg.svh"

module normShifter
(
	input logic clk,
	input logic reset,
	input logic req,
	output logic ack,
	input fixpPkg::word32 operand,
	output fixpPkg::word32 result
);

	localparam int cntW = $clog2(`CONV_SHIFT + 1);

	fixpPkg::word32 value;
	fixpPkg::word32 shifted;
	logic [cntW-1:0] shiftCnt;
	logic busy;
	logic start;

	// Rising edge of req, only once the last handshake is closed
	assign start = req && !busy && !ack;

	// One saturating step of L_shl
	always_comb
	begin
		if (value[31] != value[30])
			shifted = value[31] ? fixpPkg::minWord32 : fixpPkg::maxWord32;
		else
			shifted = value <<< 1;
	end

	////////////////////////////////////////
	// Handshake and step counter
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			ack <= 1'b0;
			shiftCnt <= '0;
		end
		else if (start)
		begin
			busy <= 1'b1;
			shiftCnt <= cntW'(`CONV_SHIFT);
		end
		else if (busy)
		begin
			shiftCnt <= shiftCnt - 1'b1;
			// Last step, ack comes up together with the final value
			if (shiftCnt == cntW'(1))
			begin
				busy <= 1'b0;
				ack <= 1'b1;
			end
		end
		else if (!req)
		begin
			ack <= 1'b0;
		end
	end

	// Value holds between ack high and the next start
	always_ff @(posedge clk)
	begin
		if (start)
			value <= operand;
		else if (busy)
			value <= shifted;
	end

	assign result = value;

endmodule

//--- design/convolve.sv
`include "conv_cfg.svh"

module convolve
(
	input logic clk,
	input logic reset,
	input logic req,
	output logic ack,
	input convPkg::blockBase xBase,
	input convPkg::blockBase hBase,
	input convPkg::blockBase yBase,
	output logic engActive,
	output convPkg::memAddr engAddr,
	output logic engWriteEn,
	output fixpPkg::memWord engWriteData,
	input fixpPkg::memWord engReadData,
	output fixpPkg::word32 macAcc,
	output fixpPkg::word16 macA,
	output fixpPkg::word16 macB,
	input fixpPkg::word32 macOut,
	output logic shlReq,
	input logic shlAck,
	output fixpPkg::word32 shlIn,
	input fixpPkg::word32 shlOut
);

	localparam convPkg::sampleIdx lastIdx = convPkg::sampleIdx'(`CONV_LEN - 1);

	convPkg::convState state;
	convPkg::convState nextState;

	// n walks the outputs, k walks the taps of one output
	convPkg::sampleIdx n;
	convPkg::sampleIdx k;

	fixpPkg::word32 acc;
	fixpPkg::word16 xSample;

	////////////////////////////////////////
	// State and loop counters
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= convPkg::idle;
		else
			state <= nextState;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			n <= '0;
			k <= '0;
		end
		else
		begin
			if (state == convPkg::idle)
				n <= '0;
			else if (state == convPkg::shiftWait && shlAck && n != lastIdx)
				n <= n + 1'b1;

			if (state == convPkg::outerCheck)
				k <= '0;
			else if (state == convPkg::mac && k != n)
				k <= k + 1'b1;
		end
	end

	////////////////////////////////////////
	// Accumulator and x latch
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (state == convPkg::outerCheck)
			acc <= '0;
		else if (state == convPkg::mac)
			acc <= macOut;

		// x[k] arrives while h[n-k] is being addressed
		if (state == convPkg::readH)
			xSample <= engReadData[`SAMPLE_W-1:0];
	end

	////////////////////////////////////////
	// Next state and memory control
	////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		engAddr = '0;
		engWriteEn = 1'b0;

		case (state)
			convPkg::idle:
				if (req)
					nextState = convPkg::outerCheck;

			convPkg::outerCheck:
				nextState = convPkg::innerCheck;

			// First tap of each output
			convPkg::innerCheck:
			begin
				engAddr = convPkg::makeAddr(xBase, k);
				nextState = convPkg::readH;
			end

			convPkg::readH:
			begin
				engAddr = convPkg::makeAddr(hBase, n - k);
				nextState = convPkg::mac;
			end

			// Fetch the next x early so each tap costs two cycles
			convPkg::mac:
				if (k == n)
					nextState = convPkg::shiftReq;
				else
				begin
					engAddr = convPkg::makeAddr(xBase, k + 1'b1);
					nextState = convPkg::readH;
				end

			// Wait for the shifter to close its previous handshake
			convPkg::shiftReq:
				if (!shlAck)
					nextState = convPkg::shiftWait;

			convPkg::shiftWait:
				if (shlAck)
				begin
					engAddr = convPkg::makeAddr(yBase, n);
					engWriteEn = 1'b1;
					nextState = (n == lastIdx) ? convPkg::finish : convPkg::outerCheck;
				end

			// Hold the result until the host lets go of req
			convPkg::finish:
				if (!req)
					nextState = convPkg::idle;

			default:
				nextState = convPkg::idle;
		endcase
	end

	assign ack = (state == convPkg::finish);

	// Also covers the idle cycle in which req first shows up
	assign engActive = (state != convPkg::idle) || req;

	// y[n] is the upper half of the shifted sum, sign extended
	assign engWriteData = {{(`DATA_W - `SAMPLE_W){shlOut[`DATA_W-1]}},
		shlOut[`DATA_W-1 -: `SAMPLE_W]};

	assign macAcc = acc;
	assign macA = xSample;
	assign macB = engReadData[`SAMPLE_W-1:0];

	assign shlReq = (state == convPkg::shiftWait);
	assign shlIn = acc;

endmodule

//--- design/convTop.sv
module convTop
(
	input logic clk,
	input logic reset,
	input logic hostWriteEn,
	input convPkg::memAddr hostAddr,
	input fixpPkg::memWord hostWriteData,
	output fixpPkg::memWord hostReadData,
	input convPkg::blockBase xBase,
	input convPkg::blockBase hBase,
	input convPkg::blockBase yBase,
	input logic req,
	output logic ack
);

	// Engine side of the memory
	logic engActive;
	convPkg::memAddr engAddr;
	logic engWriteEn;
	fixpPkg::memWord engWriteData;
	fixpPkg::memWord memReadData;

	// MAC operands
	fixpPkg::word32 macAcc;
	fixpPkg::word16 macA;
	fixpPkg::word16 macB;
	fixpPkg::word32 macOut;

	// Shifter handshake
	logic shlReq;
	logic shlAck;
	fixpPkg::word32 shlIn;
	fixpPkg::word32 shlOut;

	convolve ctrl0
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.ack(ack),
		.xBase(xBase),
		.hBase(hBase),
		.yBase(yBase),
		.engActive(engActive),
		.engAddr(engAddr),
		.engWriteEn(engWriteEn),
		.engWriteData(engWriteData),
		.engReadData(memReadData),
		.macAcc(macAcc),
		.macA(macA),
		.macB(macB),
		.macOut(macOut),
		.shlReq(shlReq),
		.shlAck(shlAck),
		.shlIn(shlIn),
		.shlOut(shlOut)
	);

	convMemory mem0
	(
		.clk(clk),
		.reset(reset),
		.hostWriteEn(hostWriteEn),
		.hostAddr(hostAddr),
		.hostWriteData(hostWriteData),
		.hostReadData(hostReadData),
		.engActive(engActive),
		.engAddr(engAddr),
		.engWriteEn(engWriteEn),
		.engWriteData(engWriteData),
		.engReadData(memReadData)
	);

	fixedMac mac0
	(
		.acc(macAcc),
		.a(macA),
		.b(macB),
		.result(macOut)
	);

	normShifter shl0
	(
		.clk(clk),
		.reset(reset),
		.req(shlReq),
		.ack(shlAck),
		.operand(shlIn),
		.result(shlOut)
	);

endmodule

//--- tb/convTop_sva.sv
`include "conv_cfg.svh"

module convTop_sva
(
	input logic clk,
	input logic reset,
	input logic req,
	input logic ack,
	input logic shlReq,
	input logic shlAck,
	input logic engWriteEn,
	input convPkg::memAddr engAddr,
	input convPkg::blockBase yBase
);

	timeunit 1ns;
	timeprecision 100ps;

	////////////////////////////////////////
	// Host handshake
	////////////////////////////////////////

	ackNeedsReq: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
		else $error("ack rose while req was low");

	ackHolds: assert property (@(posedge clk) disable iff (reset) ack && req |=> ack)
		else $error("ack dropped while req was still high");

	////////////////////////////////////////
	// Shifter handshake
	////////////////////////////////////////

	shlAckNeedsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(shlAck) |-> shlReq)
		else $error("shlAck rose while shlReq was low");

	shlAckHolds: assert property (@(posedge clk) disable iff (reset)
		shlAck && shlReq |=> shlAck)
		else $error("shlAck dropped while shlReq was still high");

	// Engine may only write words 0 to CONV_LEN-1 of the y block
	writeInYBlock: assert property (@(posedge clk) disable iff (reset)
		engWriteEn |-> engAddr[`ADDR_W-1:`IDX_W+5] == '0
			&& engAddr[`IDX_W+4:`IDX_W] == yBase
			&& int'(engAddr[`IDX_W-1:0]) < `CONV_LEN)
		else $error("engine write outside the y block at %h", engAddr);

endmodule

bind convTop convTop_sva sva0
(
	.clk(clk),
	.reset(reset),
	.req(req),
	.ack(ack),
	.shlReq(shlReq),
	.shlAck(shlAck),
	.engWriteEn(engWriteEn),
	.engAddr(engAddr),
	.yBase(yBase)
);

//--- tb/convTop_tb.sv
`include "conv_cfg.svh"

module convTop_tb;

	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [1:0] {patRandom, patMin, patLargePos, patImpulse} patKind;

	typedef struct packed
	{
		patKind kind;
		convPkg::blockBase xBase;
		convPkg::blockBase hBase;
		convPkg::blockBase yBase;
	} caseRow;

	localparam int numCases = 5;
	localparam int caseCycles = `CONV_LEN * (2 * `CONV_LEN + 12);
	localparam int watchdogCycles = 2 * caseCycles * numCases;

	// Last run reuses the y block of the first with new x and h blocks
	localparam caseRow caseTable [numCases] = '{
		'{patRandom, 5'd0, 5'd1, 5'd2},
		'{patMin, 5'd3, 5'd4, 5'd5},
		'{patLargePos, 5'd6, 5'd7, 5'd8},
		'{patImpulse, 5'd9, 5'd10, 5'd11},
		'{patRandom, 5'd31, 5'd20, 5'd2}
	};
	string caseNames [numCases] = '{"randomSmall", "allMin", "largePos", "impulse",
		"randomBackToBack"};

	logic clk;
	logic reset;
	logic hostWriteEn;
	convPkg::memAddr hostAddr;
	fixpPkg::memWord hostWriteData;
	fixpPkg::memWord hostReadData;
	convPkg::blockBase xBase;
	convPkg::blockBase hBase;
	convPkg::blockBase yBase;
	logic req;
	logic ack;

	logic [15:0] lfsr = 16'd62;
	fixpPkg::word16 xVals [`CONV_LEN];
	fixpPkg::word16 hVals [`CONV_LEN];
	fixpPkg::word16 yModel [`CONV_LEN];

	convTop dut0
	(
		.clk(clk),
		.reset(reset),
		.hostWriteEn(hostWriteEn),
		.hostAddr(hostAddr),
		.hostWriteData(hostWriteData),
		.hostReadData(hostReadData),
		.xBase(xBase),
		.hBase(hBase),
		.yBase(yBase),
		.req(req),
		.ack(ack)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// Galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		else
			return s >> 1;
	endfunction

	function automatic logic [15:0] takeBits(int count);
		logic [15:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			bits = {bits[14:0], lfsr[0]};
			lfsr = lfsrNext(lfsr);
		end
		return bits;
	endfunction

	// Sign extended sample of the given width
	function automatic fixpPkg::word16 randomSample(int width);
		logic [15:0] raw;
		raw = takeBits(width);
		return fixpPkg::word16'($signed(raw << (16 - width)) >>> (16 - width));
	endfunction

	function automatic convPkg::memAddr blockAddr(convPkg::blockBase base, int idx);
		return convPkg::memAddr'(int'(base) * (1 << `IDX_W) + idx);
	endfunction

	function automatic fixpPkg::memWord toMemWord(fixpPkg::word16 v);
		return fixpPkg::memWord'(fixpPkg::word32'(v));
	endfunction

	function automatic void fillPattern(patKind kind);
		for (int j = 0; j < `CONV_LEN; j++)
		begin
			case (kind)
				patRandom:
				begin
					xVals[j] = randomSample(12);
					hVals[j] = randomSample(12);
				end
				patMin:
				begin
					xVals[j] = 16'sh8000;
					hVals[j] = 16'sh8000;
				end
				patLargePos:
				begin
					xVals[j] = 16'sh7FFF;
					hVals[j] = 16'sh6000;
				end
				default:
				begin
					xVals[j] = (j == 0) ? 16'sh7FFF : 16'sh0000;
					hVals[j] = randomSample(16);
				end
			endcase
		end
	endfunction

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic fixpPkg::word32 sat32(longint v);
		if (v > 64'sd2147483647)
			return 32'sh7FFF_FFFF;
		else if (v < -64'sd2147483648)
			return 32'sh8000_0000;
		else
			return fixpPkg::word32'(v);
	endfunction

	function automatic fixpPkg::word32 lMult(fixpPkg::word16 a, fixpPkg::word16 b);
		return sat32(longint'(a) * longint'(b) * 64'sd2);
	endfunction

	function automatic fixpPkg::word32 lAdd(fixpPkg::word32 a, fixpPkg::word32 b);
		return sat32(longint'(a) + longint'(b));
	endfunction

	// Saturation is checked after every single bit
	function automatic fixpPkg::word32 lShl(fixpPkg::word32 v, int count);
		fixpPkg::word32 r;
		r = v;
		for (int i = 0; i < count; i++)
			r = sat32(longint'(r) * 64'sd2);
		return r;
	endfunction

	function automatic void computeModel();
		fixpPkg::word32 acc;
		fixpPkg::word32 shifted;
		for (int n = 0; n < `CONV_LEN; n++)
		begin
			acc = '0;
			for (int k = 0; k <= n; k++)
				acc = lAdd(acc, lMult(xVals[k], hVals[n - k]));
			shifted = lShl(acc, `CONV_SHIFT);
			yModel[n] = shifted[31:16];
		end
	endfunction

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic checkWord16(string testName, fixpPkg::word16 expected,
		fixpPkg::word16 actual);
		if (actual !== expected)
		begin
			$display("** Error: %s expected %h actual %h", testName, expected, actual);
			$display("Test failed");
			$fatal(1, "sample mismatch");
		end
	endtask

	task automatic checkAck(string testName, logic expected, logic actual);
		if (actual !== expected)
		begin
			$display("** Error: %s expected %b actual %b", testName, expected, actual);
			$display("Test failed");
			$fatal(1, "handshake level mismatch");
		end
	endtask

	////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////

	task automatic writeWord(convPkg::memAddr a, fixpPkg::memWord d);
		@(posedge clk);
		hostWriteEn <= 1'b1;
		hostAddr <= a;
		hostWriteData <= d;
	endtask

	// One cycle of registered read latency
	task automatic readSample(convPkg::memAddr a, output fixpPkg::word16 v);
		@(posedge clk);
		hostAddr <= a;
		@(posedge clk);
		@(negedge clk);
		v = hostReadData[`SAMPLE_W-1:0];
	endtask

	task automatic loadVectors(caseRow row);
		for (int j = 0; j < `CONV_LEN; j++)
		begin
			writeWord(blockAddr(row.xBase, j), toMemWord(xVals[j]));
			writeWord(blockAddr(row.hBase, j), toMemWord(hVals[j]));
		end
		@(posedge clk);
		hostWriteEn <= 1'b0;
	endtask

	task automatic runConv(string name, caseRow row);
		@(negedge clk);
		checkAck({name, " ack idle"}, 1'b0, ack);
		@(posedge clk);
		xBase <= row.xBase;
		hBase <= row.hBase;
		yBase <= row.yBase;
		req <= 1'b1;
		// Lands while the engine owns memory, x[0] must survive
		hostWriteEn <= 1'b1;
		hostAddr <= blockAddr(row.xBase, 0);
		hostWriteData <= ~toMemWord(xVals[0]);
		@(posedge clk);
		hostWriteEn <= 1'b0;
		@(negedge clk);
		while (ack !== 1'b1)
			@(negedge clk);
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		checkAck({name, " ack hold"}, 1'b1, ack);
		@(negedge clk);
		checkAck({name, " ack release"}, 1'b0, ack);
	endtask

	task automatic checkVectors(string name, caseRow row);
		fixpPkg::word16 v;
		for (int j = 0; j < `CONV_LEN; j++)
		begin
			readSample(blockAddr(row.xBase, j), v);
			checkWord16($sformatf("%s x[%0d]", name, j), xVals[j], v);
			readSample(blockAddr(row.hBase, j), v);
			checkWord16($sformatf("%s h[%0d]", name, j), hVals[j], v);
			readSample(blockAddr(row.yBase, j), v);
			checkWord16($sformatf("%s y[%0d]", name, j), yModel[j], v);
			if (row.kind == patLargePos)
				checkWord16($sformatf("%s y[%0d] clamp", name, j), 16'sh7FFF, v);
		end
	endtask

	////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		hostWriteEn = 1'b0;
		hostAddr = '0;
		hostWriteData = '0;
		xBase = '0;
		hBase = '0;
		yBase = '0;
		req = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkAck("reset", 1'b0, ack);
		for (int i = 0; i < numCases; i++)
		begin
			fillPattern(caseTable[i].kind);
			computeModel();
			loadVectors(caseTable[i]);
			runConv(caseNames[i], caseTable[i]);
			checkVectors(caseNames[i], caseTable[i]);
		end
		$display("Test passed");
		$finish;
	end

	initial
	begin
		repeat (watchdogCycles) @(posedge clk);
		$display("Test failed");
		$fatal(1, "watchdog timeout, ack never arrived");
	end

endmodule

//--- all.f
+incdir+include
design/fixpPkg.sv
design/convPkg.sv
design/convMemory.sv
design/fixedMac.sv
design/normShifter.sv
design/convolve.sv
design/convTop.sv
tb/convTop_sva.sv
tb/convTop_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module convTop_tb -f all.f -o simv

output=$(./obj_dir/simv 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi
